// ==== design/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

  localparam int xlen = 32;

  // pattern history table, indexed by low pc bits
  localparam int bht_index_w = 8;
  localparam int bht_entries = 256;
  localparam int hist_w      = 2;
  localparam int hist_pats   = 2 ** hist_w; // patterns per row
  localparam int tag_w       = xlen - bht_index_w;

  localparam int opcode_w = 7;
  localparam logic [opcode_w-1:0] opcode_jal    = 7'b1101111;
  localparam logic [opcode_w-1:0] opcode_jalr   = 7'b1100111;
  localparam logic [opcode_w-1:0] opcode_branch = 7'b1100011;

  // 2-bit saturating counters, upper bit is the taken guess
  localparam int ctr_w = 2;
  localparam logic [ctr_w-1:0] ctr_init = 2'b01; // weakly not-taken

  localparam int queue_depth = 4;
  localparam int queue_ptr_w = $clog2(queue_depth);
  localparam int queue_cnt_w = queue_ptr_w + 1;

  localparam int stat_w = 32;

  // one predicted jump waiting for its outcome
  typedef struct packed {
    logic [xlen-1:0]   pc;
    logic [hist_w-1:0] hist;      // history at lookup time
    logic [xlen-1:0]   pred_next;
  } pred_entry_t;

endpackage

`default_nettype wire

// ==== design/pred_entry_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface pred_entry_if;

  logic                push;
  bp_pkg::pred_entry_t entry;
  logic                pending;
  logic                pop;
  bp_pkg::pred_entry_t head;
  logic                flush;

  modport lookup    (output push, output entry);
  modport queue_in  (input push, input entry);
  modport queue_out (output pending, output head, input pop, input flush);
  modport resolve   (input pending, input head, output pop, output flush);

endinterface

`default_nettype wire

// ==== design/table_update_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface table_update_if;

  logic                           upd;    // one-cycle strobe
  logic [bp_pkg::bht_index_w-1:0] idx;
  logic [bp_pkg::hist_w-1:0]      hist;
  logic                           taken;
  logic [bp_pkg::tag_w-1:0]       tag;
  logic [bp_pkg::xlen-1:0]        target;

  modport resolve (
    output upd, output idx, output hist,
    output taken, output tag, output target
  );

  modport tables (
    input upd, input idx, input hist,
    input taken, input tag, input target
  );

endinterface

`default_nettype wire

// ==== design/bp_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_lookup (
  input  wire logic                    clk,
  input  wire logic                    rstn,
  input  wire logic                    fetch_valid,
  input  wire logic                    fetch_ready,
  input  wire logic [bp_pkg::xlen-1:0] fetch_pc,
  input  wire logic [bp_pkg::xlen-1:0] fetch_instr,
  output logic                         pred_valid,
  output logic [bp_pkg::xlen-1:0]      pred_next_pc,
  pred_entry_if.lookup                 q,
  table_update_if.tables               upd
);

  logic [bp_pkg::ctr_w-1:0]  bht [bp_pkg::bht_entries][bp_pkg::hist_pats];
  logic [bp_pkg::tag_w-1:0]  btc_tag [bp_pkg::bht_entries];
  logic [bp_pkg::xlen-1:0]   btc_target [bp_pkg::bht_entries];
  logic [bp_pkg::hist_w-1:0] ghist;

  logic [bp_pkg::opcode_w-1:0]    opcode;
  logic                           is_jump;
  logic                           accept;
  logic                           hit;
  logic [bp_pkg::bht_index_w-1:0] idx;
  logic [bp_pkg::tag_w-1:0]       tag;
  logic [bp_pkg::xlen-1:0]        pred;
  logic [bp_pkg::ctr_w-1:0]       ctr_cur;
  logic [bp_pkg::ctr_w-1:0]       ctr_next;

  assign opcode  = fetch_instr[bp_pkg::opcode_w-1:0];
  assign is_jump = opcode inside {bp_pkg::opcode_jal, bp_pkg::opcode_jalr,
                                  bp_pkg::opcode_branch};
  assign accept  = fetch_valid && fetch_ready;

  assign idx = fetch_pc[bp_pkg::bht_index_w-1:0];
  assign tag = fetch_pc[bp_pkg::xlen-1:bp_pkg::bht_index_w];

  // taken guess needs a matching target cache row too
  assign hit  = bht[idx][ghist][bp_pkg::ctr_w-1] && (btc_tag[idx] == tag);
  assign pred = (is_jump && hit) ? btc_target[idx] : fetch_pc + 1'b1;

  assign q.push  = accept && is_jump;
  assign q.entry = '{pc: fetch_pc, hist: ghist, pred_next: pred};

  // saturating step for the resolved row
  assign ctr_cur = bht[upd.idx][upd.hist];

  always_comb begin
    if (upd.taken) begin
      ctr_next = (ctr_cur == '1) ? ctr_cur : ctr_cur + 1'b1;
    end else begin
      ctr_next = (ctr_cur == '0) ? ctr_cur : ctr_cur - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < bp_pkg::bht_entries; i++) begin
        for (int j = 0; j < bp_pkg::hist_pats; j++) begin
          bht[i][j] <= bp_pkg::ctr_init;
        end
        btc_tag[i]    <= '0;
        btc_target[i] <= '0;
      end
      ghist      <= '0;
      pred_valid <= 1'b0;
    end else begin
      pred_valid <= accept;
      if (upd.upd) begin
        bht[upd.idx][upd.hist] <= ctr_next;
        ghist <= {ghist[bp_pkg::hist_w-2:0], upd.taken};
        if (upd.taken) begin
          btc_tag[upd.idx]    <= upd.tag;
          btc_target[upd.idx] <= upd.target;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) pred_next_pc <= pred;
  end

endmodule

`default_nettype wire

// ==== design/pred_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module pred_queue (
  input  wire logic      clk,
  input  wire logic      rstn,
  pred_entry_if.queue_in  in_q,
  pred_entry_if.queue_out out_q,
  output logic           full
);

  bp_pkg::pred_entry_t mem [bp_pkg::queue_depth];

  logic [bp_pkg::queue_ptr_w-1:0] head_ptr;
  logic [bp_pkg::queue_ptr_w-1:0] tail_ptr;
  logic [bp_pkg::queue_cnt_w-1:0] count;
  logic                           do_push;
  logic                           do_pop;

  assign full          = (count == bp_pkg::queue_depth[bp_pkg::queue_cnt_w-1:0]);
  assign out_q.pending = (count != '0);
  assign out_q.head    = mem[head_ptr];

  // wrong-path push is dropped when flushing
  assign do_push = in_q.push && !full && !out_q.flush;
  assign do_pop  = out_q.pop && out_q.pending;

  always_ff @(posedge clk) begin
    if (rstn) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else if (out_q.flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (do_push) tail_ptr <= tail_ptr + 1'b1; // depth is a power of two
      if (do_pop) head_ptr <= head_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[tail_ptr] <= in_q.entry;
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rstn)
    out_q.pop |-> out_q.pending);

  a_no_push_full: assert property (@(posedge clk) disable iff (rstn)
    in_q.push |-> !full);

endmodule

`default_nettype wire

// ==== design/bp_resolve.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_resolve (
  input  wire logic                    clk,
  input  wire logic                    rstn,
  input  wire logic                    resolve_valid,
  input  wire logic                    resolve_taken,
  input  wire logic [bp_pkg::xlen-1:0] resolve_target,
  pred_entry_if.resolve                q,
  table_update_if.resolve              upd,
  output logic                         mispredict,
  output logic [bp_pkg::xlen-1:0]      redirect_pc,
  output logic [bp_pkg::stat_w-1:0]    stat_total,
  output logic [bp_pkg::stat_w-1:0]    stat_correct,
  output logic [bp_pkg::stat_w-1:0]    stat_wrong
);

  logic                    fire;
  logic                    miss;
  logic [bp_pkg::xlen-1:0] actual_next;

  assign fire        = resolve_valid && q.pending;
  assign actual_next = resolve_taken ? resolve_target : q.head.pc + 1'b1;
  assign miss        = fire && (actual_next != q.head.pred_next);

  assign q.pop   = fire;
  assign q.flush = miss; // entries behind the head are wrong-path

  // training data comes from the head, not the current fetch
  assign upd.upd    = fire;
  assign upd.idx    = q.head.pc[bp_pkg::bht_index_w-1:0];
  assign upd.tag    = q.head.pc[bp_pkg::xlen-1:bp_pkg::bht_index_w];
  assign upd.hist   = q.head.hist;
  assign upd.taken  = resolve_taken;
  assign upd.target = resolve_target;

  always_ff @(posedge clk) begin
    if (rstn) begin
      mispredict   <= 1'b0;
      stat_total   <= '0;
      stat_correct <= '0;
      stat_wrong   <= '0;
    end else begin
      mispredict <= miss;
      if (fire) begin
        stat_total <= stat_total + 1'b1;
        if (miss) begin
          stat_wrong <= stat_wrong + 1'b1;
        end else begin
          stat_correct <= stat_correct + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss) redirect_pc <= actual_next;
  end

  // outcomes only come for jumps already predicted
  a_resolve_pending: assert property (@(posedge clk) disable iff (rstn)
    resolve_valid |-> q.pending);

endmodule

`default_nettype wire

// ==== design/branch_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
  input  wire logic                    clk,
  input  wire logic                    rstn,
  input  wire logic                    fetch_valid,
  input  wire logic [bp_pkg::xlen-1:0] fetch_pc,
  input  wire logic [bp_pkg::xlen-1:0] fetch_instr,
  input  wire logic                    resolve_valid,
  input  wire logic                    resolve_taken,
  input  wire logic [bp_pkg::xlen-1:0] resolve_target,
  output logic                         fetch_ready,
  output logic                         pred_valid,
  output logic [bp_pkg::xlen-1:0]      pred_next_pc,
  output logic                         mispredict,
  output logic [bp_pkg::xlen-1:0]      redirect_pc,
  output logic [bp_pkg::stat_w-1:0]    stat_total,
  output logic [bp_pkg::stat_w-1:0]    stat_correct,
  output logic [bp_pkg::stat_w-1:0]    stat_wrong
);

  logic queue_full;

  pred_entry_if   lookup_q ();  // lookup to queue
  pred_entry_if   resolve_q (); // queue to resolve
  table_update_if upd_if ();

  assign fetch_ready = !queue_full;

  bp_lookup bp_lookup_inst (
    .clk          (clk),
    .rstn         (rstn),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr),
    .pred_valid   (pred_valid),
    .pred_next_pc (pred_next_pc),
    .q            (lookup_q.lookup),
    .upd          (upd_if.tables)
  );

  pred_queue pred_queue_inst (
    .clk   (clk),
    .rstn  (rstn),
    .in_q  (lookup_q.queue_in),
    .out_q (resolve_q.queue_out),
    .full  (queue_full)
  );

  bp_resolve bp_resolve_inst (
    .clk            (clk),
    .rstn           (rstn),
    .resolve_valid  (resolve_valid),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .q              (resolve_q.resolve),
    .upd            (upd_if.resolve),
    .mispredict     (mispredict),
    .redirect_pc    (redirect_pc),
    .stat_total     (stat_total),
    .stat_correct   (stat_correct),
    .stat_wrong     (stat_wrong)
  );

endmodule

`default_nettype wire

// ==== test/bp_model.svh ====
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH
`default_nettype none

logic [bp_pkg::ctr_w-1:0]  m_ctr [bp_pkg::bht_entries][bp_pkg::hist_pats];
logic [bp_pkg::tag_w-1:0]  m_tag [bp_pkg::bht_entries];
logic [bp_pkg::xlen-1:0]   m_target [bp_pkg::bht_entries];
logic [bp_pkg::hist_w-1:0] m_hist;
bp_pkg::pred_entry_t       m_queue [$]; // oldest pending jump at index 0
int unsigned               m_total;
int unsigned               m_correct;
int unsigned               m_wrong;

task automatic model_reset();
  for (int i = 0; i < bp_pkg::bht_entries; i++) begin
    for (int j = 0; j < bp_pkg::hist_pats; j++) begin
      m_ctr[i][j] = bp_pkg::ctr_init;
    end
    m_tag[i]    = '0;
    m_target[i] = '0;
  end
  m_hist = '0;
  m_queue.delete();
  m_total   = 0;
  m_correct = 0;
  m_wrong   = 0;
endtask

function automatic logic is_jump_op(input logic [31:0] instr);
  return (instr[6:0] == bp_pkg::opcode_jal) || (instr[6:0] == bp_pkg::opcode_jalr) ||
         (instr[6:0] == bp_pkg::opcode_branch);
endfunction

// next pc the predictor should give for this fetch
function automatic logic [31:0] expected_next(input logic [31:0] pc, input logic [31:0] instr);
  logic [bp_pkg::bht_index_w-1:0] row;
  row = pc[bp_pkg::bht_index_w-1:0];
  if (is_jump_op(instr) && m_ctr[row][m_hist][1] && (m_tag[row] == pc[31:bp_pkg::bht_index_w]))
    return m_target[row];
  return pc + 32'd1;
endfunction

task automatic model_resolve(input logic taken, input logic [31:0] target,
                             output logic miss, output logic [31:0] actual);
  bp_pkg::pred_entry_t h;
  logic [bp_pkg::bht_index_w-1:0] row;
  h = m_queue.pop_front();
  row = h.pc[bp_pkg::bht_index_w-1:0];
  actual = taken ? target : h.pc + 32'd1;
  miss = (actual != h.pred_next);
  if (taken) begin
    if (m_ctr[row][h.hist] != 2'b11) m_ctr[row][h.hist] = m_ctr[row][h.hist] + 2'd1;
    m_tag[row]    = h.pc[31:bp_pkg::bht_index_w];
    m_target[row] = target;
  end else if (m_ctr[row][h.hist] != 2'b00) begin
    m_ctr[row][h.hist] = m_ctr[row][h.hist] - 2'd1;
  end
  m_hist = {m_hist[bp_pkg::hist_w-2:0], taken};
  m_total++;
  if (miss) begin
    m_wrong++;
    m_queue.delete(); // wrong-path entries go
  end else begin
    m_correct++;
  end
endtask

`default_nettype wire
`endif

// ==== test/tb_branch_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_branch_predictor;

  localparam int clk_period    = 40;
  localparam int reset_cycles  = 10;
  localparam int n_reset_jumps = 6;
  localparam int n_non_jumps   = 20;
  localparam int n_train       = 8;
  localparam int n_random      = 40;
  localparam int planned_ops   = reset_cycles + 2 * n_reset_jumps + n_non_jumps +
                                 2 * n_train + 2 * n_random + 6 * bp_pkg::queue_depth + 16;
  localparam logic [31:0] instr_addi = 32'h0000_0013;

  // what the DUT outputs should be after one rising edge
  typedef struct packed {
    int unsigned eff;
    logic        pred_valid;
    logic [31:0] pred_pc;
    logic        mispredict;
    logic [31:0] redirect;
    logic        ready;
    logic [31:0] total;
    logic [31:0] correct;
    logic [31:0] wrong;
  } expect_t;

  logic        clk;
  logic        rstn;
  logic        fetch_valid;
  logic [31:0] fetch_pc;
  logic [31:0] fetch_instr;
  logic        resolve_valid;
  logic        resolve_taken;
  logic [31:0] resolve_target;
  logic        fetch_ready;
  logic        pred_valid;
  logic [31:0] pred_next_pc;
  logic        mispredict;
  logic [31:0] redirect_pc;
  logic [31:0] stat_total;
  logic [31:0] stat_correct;
  logic [31:0] stat_wrong;

  int unsigned cyc_count = 0;
  int unsigned value_errors = 0;
  int unsigned other_errors = 0;
  int unsigned resolves_sent = 0;
  expect_t     exp_q [$];
  expect_t     cur;

  `include "bp_model.svh"

  branch_predictor branch_predictor_inst (
    .clk            (clk),
    .rstn           (rstn),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .resolve_valid  (resolve_valid),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .fetch_ready    (fetch_ready),
    .pred_valid     (pred_valid),
    .pred_next_pc   (pred_next_pc),
    .mispredict     (mispredict),
    .redirect_pc    (redirect_pc),
    .stat_total     (stat_total),
    .stat_correct   (stat_correct),
    .stat_wrong     (stat_wrong)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cyc_count <= cyc_count + 1;

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
    value_errors++;
  endtask

  function automatic logic [31:0] random_jump();
    logic [31:0] r;
    r = $urandom;
    case (r[31:30])
      2'd0:    r[6:0] = bp_pkg::opcode_jal;
      2'd1:    r[6:0] = bp_pkg::opcode_jalr;
      default: r[6:0] = bp_pkg::opcode_branch;
    endcase
    return r;
  endfunction

  // drive one cycle and record what the following edge should produce
  task automatic step(input logic fv, input logic [31:0] pc, input logic [31:0] instr,
                      input logic rv, input logic rt, input logic [31:0] rtarget);
    expect_t             e;
    bp_pkg::pred_entry_t ent;
    logic                fire;
    logic                accept;
    logic                miss;
    logic [31:0]         actual;
    @(negedge clk);
    fire   = rv && (m_queue.size() != 0);
    accept = fv && (m_queue.size() < bp_pkg::queue_depth);
    fetch_valid    = fv;
    fetch_pc       = pc;
    fetch_instr    = instr;
    resolve_valid  = fire;
    resolve_taken  = rt;
    resolve_target = rtarget;
    ent.pc        = pc;
    ent.hist      = m_hist;
    ent.pred_next = expected_next(pc, instr); // tables as before the edge
    miss   = 1'b0;
    actual = '0;
    if (fire) begin
      model_resolve(rt, rtarget, miss, actual);
      resolves_sent++;
    end
    if (accept && is_jump_op(instr) && !miss) m_queue.push_back(ent);
    e.eff        = cyc_count + 1;
    e.pred_valid = accept;
    e.pred_pc    = ent.pred_next;
    e.mispredict = miss;
    e.redirect   = actual;
    e.ready      = (m_queue.size() < bp_pkg::queue_depth);
    e.total      = m_total;
    e.correct    = m_correct;
    e.wrong      = m_wrong;
    exp_q.push_back(e);
  endtask

  task automatic idle();
    step(1'b0, '0, instr_addi, 1'b0, 1'b0, '0);
  endtask

  task automatic fetch_jump(input logic [31:0] pc);
    step(1'b1, pc, random_jump(), 1'b0, 1'b0, '0);
  endtask

  task automatic resolve_only(input logic taken, input logic [31:0] target);
    step(1'b0, '0, instr_addi, 1'b1, taken, target);
  endtask

  task automatic resolve_as_predicted();
    bp_pkg::pred_entry_t h;
    h = m_queue[0];
    resolve_only(h.pred_next != h.pc + 32'd1, h.pred_next);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    while (exp_q.size() != 0 && exp_q[0].eff <= cyc_count) begin
      cur = exp_q.pop_front();
      if (pred_valid !== cur.pred_valid) report_mismatch("pred_valid", cur.pred_valid, pred_valid);
      if (cur.pred_valid && pred_next_pc !== cur.pred_pc)
        report_mismatch("pred_next_pc", cur.pred_pc, pred_next_pc);
      if (mispredict !== cur.mispredict) report_mismatch("mispredict", cur.mispredict, mispredict);
      if (cur.mispredict && redirect_pc !== cur.redirect)
        report_mismatch("redirect_pc", cur.redirect, redirect_pc);
      if (fetch_ready !== cur.ready) report_mismatch("fetch_ready", cur.ready, fetch_ready);
      if (stat_total !== cur.total) report_mismatch("stat_total", cur.total, stat_total);
      if (stat_correct !== cur.correct) report_mismatch("stat_correct", cur.correct, stat_correct);
      if (stat_wrong !== cur.wrong) report_mismatch("stat_wrong", cur.wrong, stat_wrong);
    end
  end

  initial begin
    repeat (planned_ops * 10) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", planned_ops * 10);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [31:0] pc;
    logic [31:0] target;
    void'($urandom(32456));
    rstn           = 1'b1;
    fetch_valid    = 1'b0;
    fetch_pc       = '0;
    fetch_instr    = instr_addi;
    resolve_valid  = 1'b0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    model_reset();
    repeat (reset_cycles) @(negedge clk);
    rstn = 1'b0;

    // fresh tables, every jump falls through
    for (int i = 0; i < n_reset_jumps; i++) begin
      fetch_jump($urandom);
      resolve_only(1'b0, '0);
    end
    for (int i = 0; i < n_non_jumps; i++) begin
      step(1'b1, $urandom, instr_addi | ($urandom & 32'hffff_ff80), 1'b0, 1'b0, '0);
    end

    pc     = 32'h0000_1234;
    target = 32'h0000_2000;
    for (int i = 0; i < n_train; i++) begin
      fetch_jump(pc);
      resolve_only(1'b1, target);
    end
    // last trained fetch must have predicted the target
    if (pred_next_pc !== target) begin
      $display("Training never reached a taken prediction for pc %h", pc);
      other_errors++;
    end

    // small pc set so rows get reused
    resolves_sent = 0;
    for (int i = 0; i < n_random; i++) begin
      pc = 32'h0000_0100 + $urandom_range(0, 15);
      fetch_jump(pc);
      resolve_only(1'($urandom_range(0, 1)), pc + 32'h40);
    end
    idle();
    idle();
    if (stat_total != resolves_sent + n_reset_jumps + n_train) begin
      $display("stat_total %0d does not match the %0d resolves sent", stat_total,
               resolves_sent + n_reset_jumps + n_train);
      other_errors++;
    end
    if (stat_correct + stat_wrong != stat_total) begin
      $display("stat_correct plus stat_wrong does not add up to stat_total");
      other_errors++;
    end

    for (int i = 0; i < bp_pkg::queue_depth; i++) fetch_jump(32'h0000_3000 + 32'(i * 16));
    fetch_jump(32'h0000_3100); // refused, queue full
    if (fetch_ready !== 1'b0) begin
      $display("fetch_ready stayed high with a full queue");
      other_errors++;
    end
    resolve_as_predicted();
    idle();
    if (fetch_ready !== 1'b1) begin
      $display("fetch_ready did not return high after a resolve");
      other_errors++;
    end
    while (m_queue.size() != 0) resolve_as_predicted();

    fetch_jump(32'h0000_5000);
    fetch_jump(32'h0000_5010);
    fetch_jump(32'h0000_5020);
    step(1'b1, 32'h0000_5030, random_jump(), 1'b1, 1'b1, 32'h0000_7777);
    idle();
    if (mispredict !== 1'b1 || fetch_ready !== 1'b1) begin
      $display("Resolve of the oldest jump did not mispredict with fetch_ready high");
      other_errors++;
    end
    // a full refill only fits if the old entries are gone
    for (int i = 0; i < bp_pkg::queue_depth; i++) fetch_jump(32'h0000_6000 + 32'(i * 16));
    while (m_queue.size() != 0) resolve_as_predicted();

    idle();
    idle();
    repeat (2) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("Some expected responses were never compared");
      other_errors++;
    end
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
design/bp_pkg.sv
design/pred_entry_if.sv
design/table_update_if.sv
design/bp_lookup.sv
design/pred_queue.sv
design/bp_resolve.sv
design/branch_predictor.sv
test/tb_branch_predictor.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, status follows the testbench result
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_branch_predictor -o tb_branch_predictor \
  && ./obj_dir/tb_branch_predictor | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }
